// ==== rtl/rs_pkg.sv ====
package rs_pkg;

  // fixed by the core, not by the station depth
  localparam int ROB_ID_W = 5;
  localparam int DATA_W = 32;

  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_SLL = 4'd6,
    OP_SRL = 4'd7,
    OP_SLT = 4'd8,
    OP_BEQ = 4'd9,
    OP_BNE = 4'd10
  } rs_op_e;

  // busy means value is not there yet, wait for tag
  typedef struct packed {
    logic                busy;
    logic [ROB_ID_W-1:0] tag;
    logic [DATA_W-1:0]   value;
  } rs_operand_t;

  typedef struct packed {
    rs_op_e              op;
    rs_operand_t         src1;
    rs_operand_t         src2;
    logic [DATA_W-1:0]   imm;
    logic                use_imm;
    logic [DATA_W-1:0]   pc;
    logic [ROB_ID_W-1:0] rob_id;
  } rs_dispatch_t;

  typedef struct packed {
    logic                valid;
    rs_op_e              op;
    logic [DATA_W-1:0]   vi;
    logic [DATA_W-1:0]   vj;
    logic [DATA_W-1:0]   imm;
    logic                use_imm;
    logic [DATA_W-1:0]   pc;
    logic [ROB_ID_W-1:0] rob_id;
  } rs_issue_t;

  typedef struct packed {
    logic                valid;
    logic [ROB_ID_W-1:0] rob_id;
    logic [DATA_W-1:0]   value;
  } cdb_t;

  // fill a waiting operand from whichever bus carries its tag
  // load/store bus has priority over the alu bus
  function automatic rs_operand_t snoop_operand(rs_operand_t opnd, cdb_t alu_cdb,
                                                cdb_t lsb_cdb);
    rs_operand_t res;
    res = opnd;
    if (opnd.busy) begin
      if (lsb_cdb.valid && lsb_cdb.rob_id == opnd.tag) begin
        res.busy  = 1'b0;
        res.value = lsb_cdb.value;
      end else if (alu_cdb.valid && alu_cdb.rob_id == opnd.tag) begin
        res.busy  = 1'b0;
        res.value = alu_cdb.value;
      end
    end
    return res;
  endfunction

endpackage

// ==== rtl/rs_alloc.sv ====
`timescale 1ns/1ns

module rs_alloc #(
  parameter int RS_DEPTH_BIT = 3,
  localparam int RS_SLOTS = 2 ** RS_DEPTH_BIT
) (
  input  logic                 disp_valid_i,
  input  rs_pkg::rs_dispatch_t disp_i,
  input  rs_pkg::cdb_t         alu_cdb_i,
  input  rs_pkg::cdb_t         lsb_cdb_i,
  input  logic [RS_SLOTS-1:0]  slot_valid_i,
  input  logic                 rdy_i,
  input  logic                 flush_i,
  output logic [RS_SLOTS-1:0]  wr_en_o,
  output rs_pkg::rs_dispatch_t wr_data_o,
  output logic                 full_o
);

  logic [RS_SLOTS-1:0] free_onehot;
  logic                free_found;
  logic                disp_take;

  // full comes straight from the registered slot valids
  assign full_o = &slot_valid_i;

  // a flush in the same cycle wins over the dispatch
  assign disp_take = disp_valid_i && rdy_i && !flush_i && !full_o;

  // lowest free slot
  always_comb begin
    free_onehot = '0;
    free_found  = 1'b0;
    for (int i = 0; i < RS_SLOTS; i++) begin
      if (!free_found && !slot_valid_i[i]) begin
        free_onehot[i] = 1'b1;
        free_found     = 1'b1;
      end
    end
  end

  assign wr_en_o = disp_take ? free_onehot : '0;

  // same-cycle bypass from both result buses
  always_comb begin
    wr_data_o      = disp_i;
    wr_data_o.src1 = rs_pkg::snoop_operand(disp_i.src1, alu_cdb_i, lsb_cdb_i);
    wr_data_o.src2 = rs_pkg::snoop_operand(disp_i.src2, alu_cdb_i, lsb_cdb_i);
  end

endmodule

// ==== rtl/rs_entry.sv ====
`timescale 1ns/1ns

module rs_entry (
  input  logic                 clk_in,
  input  logic                 rst_n_i,
  input  logic                 rdy_i,
  input  logic                 flush_i,
  input  logic                 wr_en_i,
  input  rs_pkg::rs_dispatch_t wr_data_i,
  input  logic                 grant_i,
  input  rs_pkg::cdb_t         alu_cdb_i,
  input  rs_pkg::cdb_t         lsb_cdb_i,
  output logic                 valid_o,
  output logic                 ready_o,
  output rs_pkg::rs_dispatch_t entry_o
);

  logic                 valid_q;
  rs_pkg::rs_dispatch_t entry_q;

  // occupancy
  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (rdy_i) begin
      // allocator only writes free slots, selector only grants valid ones
      if (wr_en_i) begin
        valid_q <= 1'b1;
      end else if (grant_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // instruction body plus operand wakeup
  always_ff @(posedge clk_in) begin
    if (rdy_i) begin
      if (wr_en_i) begin
        entry_q <= wr_data_i;
      end else begin
        entry_q.src1 <= rs_pkg::snoop_operand(entry_q.src1, alu_cdb_i, lsb_cdb_i);
        entry_q.src2 <= rs_pkg::snoop_operand(entry_q.src2, alu_cdb_i, lsb_cdb_i);
      end
    end
  end

  assign valid_o = valid_q;
  assign entry_o = entry_q;

  // both sources present
  assign ready_o = valid_q && !entry_q.src1.busy && !entry_q.src2.busy;

endmodule

// ==== rtl/rs_issue_select.sv ====
`timescale 1ns/1ns

module rs_issue_select #(
  parameter int RS_DEPTH_BIT = 3,
  localparam int RS_SLOTS = 2 ** RS_DEPTH_BIT
) (
  input  logic                 clk_in,
  input  logic                 rst_n_i,
  input  logic                 rdy_i,
  input  logic                 flush_i,
  input  logic [RS_SLOTS-1:0]  ready_i,
  input  rs_pkg::rs_dispatch_t entries_i [RS_SLOTS],
  output logic [RS_SLOTS-1:0]  grant_o,
  output rs_pkg::rs_issue_t    issue_o
);

  logic [RS_DEPTH_BIT-1:0] sel_idx;
  logic                    any_ready;
  logic [RS_SLOTS-1:0]     sel_onehot;
  rs_pkg::rs_dispatch_t    sel_entry;
  rs_pkg::rs_issue_t       issue_d;
  rs_pkg::rs_issue_t       issue_q;
  logic                    issue_vld_q;

  // lowest ready slot wins
  always_comb begin
    sel_idx    = '0;
    sel_onehot = '0;
    any_ready  = 1'b0;
    for (int i = 0; i < RS_SLOTS; i++) begin
      if (!any_ready && ready_i[i]) begin
        sel_idx       = RS_DEPTH_BIT'(i);
        sel_onehot[i] = 1'b1;
        any_ready     = 1'b1;
      end
    end
  end

  // no grant while frozen or being flushed
  assign grant_o = (rdy_i && !flush_i) ? sel_onehot : '0;

  assign sel_entry = entries_i[sel_idx];

  always_comb begin
    issue_d.valid   = any_ready;
    issue_d.op      = sel_entry.op;
    issue_d.vi      = sel_entry.src1.value;
    issue_d.vj      = sel_entry.src2.value;
    issue_d.imm     = sel_entry.imm;
    issue_d.use_imm = sel_entry.use_imm;
    issue_d.pc      = sel_entry.pc;
    issue_d.rob_id  = sel_entry.rob_id;
  end

  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_vld_q <= 1'b0;
    end else if (flush_i) begin
      issue_vld_q <= 1'b0;
    end else if (rdy_i) begin
      issue_vld_q <= issue_d.valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_i && any_ready) begin
      issue_q <= issue_d;
    end
  end

  always_comb begin
    issue_o       = issue_q;
    issue_o.valid = issue_vld_q;
  end

endmodule

// ==== rtl/rs_alu.sv ====
`timescale 1ns/1ns

module rs_alu (
  input  logic              clk_in,
  input  logic              rst_n_i,
  input  logic              rdy_i,
  input  logic              flush_i,
  input  rs_pkg::rs_issue_t issue_i,
  output rs_pkg::cdb_t      cdb_o
);

  logic [rs_pkg::DATA_W-1:0]   opnd_a;
  logic [rs_pkg::DATA_W-1:0]   opnd_b;
  logic [rs_pkg::DATA_W-1:0]   result_d;
  logic                        result_vld_d;
  logic                        br_taken;
  logic [rs_pkg::DATA_W-1:0]   br_target;
  logic [rs_pkg::DATA_W-1:0]   br_fallthru;
  logic                        cdb_vld_q;
  logic [rs_pkg::ROB_ID_W-1:0] cdb_rob_q;
  logic [rs_pkg::DATA_W-1:0]   cdb_val_q;

  assign opnd_a = issue_i.vi;
  assign opnd_b = issue_i.use_imm ? issue_i.imm : issue_i.vj;

  // branches compare the two registers, imm is the offset
  assign br_target   = issue_i.pc + issue_i.imm;
  assign br_fallthru = issue_i.pc + rs_pkg::DATA_W'(4);

  always_comb begin
    br_taken = 1'b0;
    result_d = '0;
    case (issue_i.op)
      rs_pkg::OP_ADD: result_d = opnd_a + opnd_b;
      rs_pkg::OP_SUB: result_d = opnd_a - opnd_b;
      rs_pkg::OP_AND: result_d = opnd_a & opnd_b;
      rs_pkg::OP_OR:  result_d = opnd_a | opnd_b;
      rs_pkg::OP_XOR: result_d = opnd_a ^ opnd_b;
      rs_pkg::OP_SLL: result_d = opnd_a << opnd_b[4:0];
      rs_pkg::OP_SRL: result_d = opnd_a >> opnd_b[4:0];
      rs_pkg::OP_SLT: begin
        result_d = rs_pkg::DATA_W'($signed(opnd_a) < $signed(opnd_b));
      end
      rs_pkg::OP_BEQ: begin
        br_taken = (issue_i.vi == issue_i.vj);
        result_d = br_taken ? br_target : br_fallthru;
      end
      rs_pkg::OP_BNE: begin
        br_taken = (issue_i.vi != issue_i.vj);
        result_d = br_taken ? br_target : br_fallthru;
      end
      default: result_d = '0;
    endcase
  end

  // nop leaves the bus idle
  assign result_vld_d = issue_i.valid && (issue_i.op != rs_pkg::OP_NOP);

  always_ff @(posedge clk_in or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cdb_vld_q <= 1'b0;
    end else if (flush_i) begin
      cdb_vld_q <= 1'b0;
    end else if (rdy_i) begin
      cdb_vld_q <= result_vld_d;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_i && result_vld_d) begin
      cdb_rob_q <= issue_i.rob_id;
      cdb_val_q <= result_d;
    end
  end

  assign cdb_o.valid  = cdb_vld_q;
  assign cdb_o.rob_id = cdb_rob_q;
  assign cdb_o.value  = cdb_val_q;

endmodule

// ==== rtl/rs_top.sv ====
`timescale 1ns/1ns

module rs_top #(
  parameter int RS_DEPTH_BIT = 3
) (
  input  logic                 clk_in,
  input  logic                 rst_n_i,
  input  logic                 rdy_i,
  input  logic                 flush_i,
  input  logic                 disp_valid_i,
  input  rs_pkg::rs_dispatch_t disp_i,
  input  rs_pkg::cdb_t         lsb_cdb_i,
  output logic                 full_o,
  output rs_pkg::cdb_t         alu_cdb_o
);

  localparam int RS_SLOTS = 2 ** RS_DEPTH_BIT;

  logic [RS_SLOTS-1:0]  slot_valid;
  logic [RS_SLOTS-1:0]  slot_ready;
  logic [RS_SLOTS-1:0]  slot_wr_en;
  logic [RS_SLOTS-1:0]  slot_grant;
  rs_pkg::rs_dispatch_t slot_wr_data;
  rs_pkg::rs_dispatch_t slot_entry [RS_SLOTS];
  rs_pkg::rs_issue_t    issue_pkt;
  rs_pkg::cdb_t         alu_cdb;

  // alu result also feeds wakeup inside the station
  assign alu_cdb_o = alu_cdb;

  rs_alloc #(
    .RS_DEPTH_BIT (RS_DEPTH_BIT)
  ) rs_alloc_inst (
    .disp_valid_i (disp_valid_i),
    .disp_i       (disp_i),
    .alu_cdb_i    (alu_cdb),
    .lsb_cdb_i    (lsb_cdb_i),
    .slot_valid_i (slot_valid),
    .rdy_i        (rdy_i),
    .flush_i      (flush_i),
    .wr_en_o      (slot_wr_en),
    .wr_data_o    (slot_wr_data),
    .full_o       (full_o)
  );

  // slot bank, all slots share the resolved write data
  for (genvar gi = 0; gi < RS_SLOTS; gi++) begin : gen_slot
    rs_entry rs_entry_inst (
      .clk_in    (clk_in),
      .rst_n_i   (rst_n_i),
      .rdy_i     (rdy_i),
      .flush_i   (flush_i),
      .wr_en_i   (slot_wr_en[gi]),
      .wr_data_i (slot_wr_data),
      .grant_i   (slot_grant[gi]),
      .alu_cdb_i (alu_cdb),
      .lsb_cdb_i (lsb_cdb_i),
      .valid_o   (slot_valid[gi]),
      .ready_o   (slot_ready[gi]),
      .entry_o   (slot_entry[gi])
    );
  end

  rs_issue_select #(
    .RS_DEPTH_BIT (RS_DEPTH_BIT)
  ) rs_issue_select_inst (
    .clk_in    (clk_in),
    .rst_n_i   (rst_n_i),
    .rdy_i     (rdy_i),
    .flush_i   (flush_i),
    .ready_i   (slot_ready),
    .entries_i (slot_entry),
    .grant_o   (slot_grant),
    .issue_o   (issue_pkt)
  );

  rs_alu rs_alu_inst (
    .clk_in  (clk_in),
    .rst_n_i (rst_n_i),
    .rdy_i   (rdy_i),
    .flush_i (flush_i),
    .issue_i (issue_pkt),
    .cdb_o   (alu_cdb)
  );

endmodule

// ==== verif/rs_tb.sv ====
`timescale 1ns/1ns

module rs_tb;

  localparam int CLK_PERIOD = 40;
  localparam int CDB_WAIT_MAX = 30;
  // reset, independent, dependency, lsb wakeup, fill, stall and flush
  localparam int TEST_CYCLES = 10 + 70 + 15 + 25 + 40 + 60;

  logic                 clk_in;
  logic                 rst_n_i;
  logic                 rdy_i;
  logic                 flush_i;
  logic                 disp_valid_i;
  rs_pkg::rs_dispatch_t disp_i;
  rs_pkg::cdb_t         lsb_cdb_i;
  logic                 full_o;
  rs_pkg::cdb_t         alu_cdb_o;

  logic [31:0]                 rng_state;
  logic [rs_pkg::ROB_ID_W-1:0] rob_seq;

  rs_top rs_top_inst (
    .clk_in       (clk_in),
    .rst_n_i      (rst_n_i),
    .rdy_i        (rdy_i),
    .flush_i      (flush_i),
    .disp_valid_i (disp_valid_i),
    .disp_i       (disp_i),
    .lsb_cdb_i    (lsb_cdb_i),
    .full_o       (full_o),
    .alu_cdb_o    (alu_cdb_o)
  );

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [rs_pkg::ROB_ID_W-1:0] next_rob();
    rob_seq = rob_seq + 1'b1;
    return rob_seq;
  endfunction

  function automatic rs_pkg::rs_operand_t make_operand(logic busy, logic [4:0] tag,
                                                      logic [31:0] value);
    rs_pkg::rs_operand_t opnd;
    opnd.busy  = busy;
    opnd.tag   = tag;
    opnd.value = value;
    return opnd;
  endfunction

  function automatic rs_pkg::rs_dispatch_t make_disp(rs_pkg::rs_op_e op,
      rs_pkg::rs_operand_t s1, rs_pkg::rs_operand_t s2, logic [31:0] imm,
      logic use_imm, logic [31:0] pc, logic [4:0] rob);
    rs_pkg::rs_dispatch_t d;
    d.op      = op;
    d.src1    = s1;
    d.src2    = s2;
    d.imm     = imm;
    d.use_imm = use_imm;
    d.pc      = pc;
    d.rob_id  = rob;
    return d;
  endfunction

  function automatic rs_pkg::cdb_t make_cdb(logic [4:0] rob, logic [31:0] value);
    rs_pkg::cdb_t bus;
    bus.valid  = 1'b1;
    bus.rob_id = rob;
    bus.value  = value;
    return bus;
  endfunction

  // reference ALU behavior
  function automatic logic [31:0] model_alu(rs_pkg::rs_op_e op, logic [31:0] a,
      logic [31:0] b, logic [31:0] imm, logic use_imm, logic [31:0] pc);
    logic [31:0] second;
    logic [31:0] res;
    second = use_imm ? imm : b;
    case (op)
      rs_pkg::OP_ADD: res = a + second;
      rs_pkg::OP_SUB: res = a - second;
      rs_pkg::OP_AND: res = a & second;
      rs_pkg::OP_OR:  res = a | second;
      rs_pkg::OP_XOR: res = a ^ second;
      rs_pkg::OP_SLL: res = a << second[4:0];
      rs_pkg::OP_SRL: res = a >> second[4:0];
      rs_pkg::OP_SLT: res = ($signed(a) < $signed(second)) ? 32'd1 : 32'd0;
      // branches compare the registers and ignore use_imm
      rs_pkg::OP_BEQ: res = (a == b) ? pc + imm : pc + 32'd4;
      rs_pkg::OP_BNE: res = (a != b) ? pc + imm : pc + 32'd4;
      default:        res = 32'd0;
    endcase
    return res;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_cdb(input string name, input rs_pkg::cdb_t exp, input rs_pkg::cdb_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_full(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
    end
  endtask

  // all drive tasks start and end just after a falling edge
  task automatic send_dispatch(input rs_pkg::rs_dispatch_t d, input rs_pkg::cdb_t lsb);
    disp_i       = d;
    disp_valid_i = 1'b1;
    lsb_cdb_i    = lsb;
    @(negedge clk_in);
    disp_valid_i = 1'b0;
    lsb_cdb_i    = '0;
  endtask

  task automatic pulse_lsb(input logic [4:0] rob, input logic [31:0] value);
    lsb_cdb_i = make_cdb(rob, value);
    @(negedge clk_in);
    lsb_cdb_i = '0;
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(negedge clk_in);
    flush_i = 1'b0;
  endtask

  task automatic wait_cdb(output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk_in);
      cycles++;
      seen = alu_cdb_o.valid;
      if (!seen && cycles >= CDB_WAIT_MAX) begin
        fail_run("timed out waiting for a result on the ALU bus");
      end
    end
  endtask

  task automatic expect_quiet(input string name, input int n);
    repeat (n) begin
      @(negedge clk_in);
      if (alu_cdb_o.valid) begin
        fail_run($sformatf("%s: unexpected ALU result for rob %0d", name, alu_cdb_o.rob_id));
      end
    end
  endtask

  // one ready instruction into an idle station
  task automatic run_single(input string name, input rs_pkg::rs_op_e op, input logic use_imm,
                            input logic same_regs);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc;
    logic [4:0]  rob;
    int          lat;
    a   = next_rand();
    b   = same_regs ? a : next_rand();
    imm = next_rand();
    pc  = next_rand() & 32'hffff_fffc;
    rob = next_rob();
    send_dispatch(make_disp(op, make_operand(1'b0, 5'd0, a), make_operand(1'b0, 5'd0, b),
                            imm, use_imm, pc, rob), '0);
    wait_cdb(lat);
    if (lat != 2) begin
      fail_run($sformatf("ERR %s latency expected 2 actual %0d", name, lat));
    end
    check_cdb(name, make_cdb(rob, model_alu(op, a, b, imm, use_imm, pc)), alu_cdb_o);
    expect_quiet({name, " single pulse"}, 1);
  endtask

  // a nop is issued but never shows up on the bus
  task automatic run_nop();
    send_dispatch(make_disp(rs_pkg::OP_NOP, make_operand(1'b0, 5'd0, next_rand()),
                            make_operand(1'b0, 5'd0, next_rand()), 32'd0, 1'b0, 32'd0,
                            next_rob()), '0);
    expect_quiet("nop", 4);
  endtask

  task automatic independent_ops();
    run_single("add", rs_pkg::OP_ADD, 1'b0, 1'b0);
    run_single("add imm", rs_pkg::OP_ADD, 1'b1, 1'b0);
    run_single("sub", rs_pkg::OP_SUB, 1'b0, 1'b0);
    run_single("and", rs_pkg::OP_AND, 1'b0, 1'b0);
    run_single("or imm", rs_pkg::OP_OR, 1'b1, 1'b0);
    run_single("xor", rs_pkg::OP_XOR, 1'b0, 1'b0);
    run_single("sll", rs_pkg::OP_SLL, 1'b0, 1'b0);
    run_single("sll imm", rs_pkg::OP_SLL, 1'b1, 1'b0);
    run_single("srl", rs_pkg::OP_SRL, 1'b0, 1'b0);
    run_single("slt", rs_pkg::OP_SLT, 1'b0, 1'b0);
    run_single("slt imm", rs_pkg::OP_SLT, 1'b1, 1'b0);
    run_single("beq taken", rs_pkg::OP_BEQ, 1'b0, 1'b1);
    run_single("beq not taken", rs_pkg::OP_BEQ, 1'b0, 1'b0);
    run_single("bne taken", rs_pkg::OP_BNE, 1'b0, 1'b0);
    run_nop();
  endtask

  task automatic alu_dependency();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] pv;
    logic [4:0]  rp;
    logic [4:0]  rc;
    int          lat;
    a  = next_rand();
    b  = next_rand();
    c  = next_rand();
    rp = next_rob();
    rc = next_rob();
    pv = model_alu(rs_pkg::OP_ADD, a, b, 32'd0, 1'b0, 32'd0);
    send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b0, 5'd0, a),
                            make_operand(1'b0, 5'd0, b), 32'd0, 1'b0, 32'd0, rp), '0);
    // consumer waits on the producer's rob id
    send_dispatch(make_disp(rs_pkg::OP_SUB, make_operand(1'b1, rp, next_rand()),
                            make_operand(1'b0, 5'd0, c), 32'd0, 1'b0, 32'd0, rc), '0);
    wait_cdb(lat);
    check_cdb("dep producer", make_cdb(rp, pv), alu_cdb_o);
    wait_cdb(lat);
    check_cdb("dep consumer",
              make_cdb(rc, model_alu(rs_pkg::OP_SUB, pv, c, 32'd0, 1'b0, 32'd0)), alu_cdb_o);
  endtask

  task automatic lsb_wakeup();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [4:0]  rob;
    int          lat;
    // wakeup while sitting in a slot
    b   = next_rand();
    v1  = next_rand();
    rob = next_rob();
    send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b1, 5'd20, next_rand()),
                            make_operand(1'b0, 5'd0, b), 32'd0, 1'b0, 32'd0, rob), '0);
    expect_quiet("lsb slot wait", 3);
    pulse_lsb(5'd20, v1);
    wait_cdb(lat);
    check_cdb("lsb slot wakeup", make_cdb(rob, v1 + b), alu_cdb_o);
    // bypass in the dispatch cycle
    a   = next_rand();
    v2  = next_rand();
    rob = next_rob();
    send_dispatch(make_disp(rs_pkg::OP_XOR, make_operand(1'b0, 5'd0, a),
                            make_operand(1'b1, 5'd21, next_rand()), 32'd0, 1'b0, 32'd0, rob),
                  make_cdb(5'd21, v2));
    wait_cdb(lat);
    if (lat != 2) begin
      fail_run($sformatf("ERR lsb bypass latency expected 2 actual %0d", lat));
    end
    check_cdb("lsb bypass", make_cdb(rob, a ^ v2), alu_cdb_o);
    // one operand bypassed, the other filled later
    v1  = next_rand();
    v2  = next_rand();
    rob = next_rob();
    send_dispatch(make_disp(rs_pkg::OP_OR, make_operand(1'b1, 5'd22, next_rand()),
                            make_operand(1'b1, 5'd23, next_rand()), 32'd0, 1'b0, 32'd0, rob),
                  make_cdb(5'd22, v1));
    expect_quiet("lsb half filled", 3);
    pulse_lsb(5'd23, v2);
    wait_cdb(lat);
    check_cdb("lsb mixed", make_cdb(rob, v1 | v2), alu_cdb_o);
  endtask

  // eight slots waiting on one tag
  task automatic fill_slots(input logic [4:0] tag, output logic [31:0] vals [8],
                            output logic [4:0] robs [8]);
    for (int i = 0; i < 8; i++) begin
      vals[i] = next_rand();
      robs[i] = next_rob();
      send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b1, tag, next_rand()),
                              make_operand(1'b0, 5'd0, vals[i]), 32'd0, 1'b0, 32'd0,
                              robs[i]), '0);
    end
  endtask

  task automatic fill_and_order();
    logic [31:0] vals [8];
    logic [4:0]  robs [8];
    logic [31:0] w;
    int          lat;
    fill_slots(5'd25, vals, robs);
    check_full("fill full", 1'b1, full_o);
    // ninth dispatch is ready at once and must be dropped
    send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b0, 5'd0, next_rand()),
                            make_operand(1'b0, 5'd0, next_rand()), 32'd0, 1'b0, 32'd0,
                            next_rob()), '0);
    check_full("fill ninth", 1'b1, full_o);
    expect_quiet("fill ninth", 4);
    w = next_rand();
    pulse_lsb(5'd25, w);
    for (int i = 0; i < 8; i++) begin
      wait_cdb(lat);
      if (i > 0 && lat != 1) begin
        fail_run($sformatf("ERR fill spacing expected 1 actual %0d", lat));
      end
      check_cdb($sformatf("fill order %0d", i), make_cdb(robs[i], w + vals[i]), alu_cdb_o);
    end
    check_full("fill drained", 1'b0, full_o);
    expect_quiet("fill drained", 4);
  endtask

  task automatic stall_and_flush();
    logic [31:0]  vals [8];
    logic [4:0]   robs [8];
    logic [31:0]  a;
    logic [31:0]  b;
    logic [4:0]   rob;
    rs_pkg::cdb_t held;
    int           lat;
    a   = next_rand();
    b   = next_rand();
    rob = next_rob();
    send_dispatch(make_disp(rs_pkg::OP_AND, make_operand(1'b0, 5'd0, a),
                            make_operand(1'b0, 5'd0, b), 32'd0, 1'b0, 32'd0, rob), '0);
    wait_cdb(lat);
    held = make_cdb(rob, a & b);
    check_cdb("stall before", held, alu_cdb_o);
    rdy_i = 1'b0;
    repeat (3) begin
      @(negedge clk_in);
      check_cdb("stall hold", held, alu_cdb_o);
    end
    // frozen stage drops this dispatch
    send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b0, 5'd0, next_rand()),
                            make_operand(1'b0, 5'd0, next_rand()), 32'd0, 1'b0, 32'd0,
                            next_rob()), '0);
    check_cdb("stall dispatch", held, alu_cdb_o);
    rdy_i = 1'b1;
    expect_quiet("after stall", 6);
    // flush with one result on the bus and the next one in the issue register
    a   = next_rand();
    b   = next_rand();
    rob = next_rob();
    send_dispatch(make_disp(rs_pkg::OP_ADD, make_operand(1'b0, 5'd0, a),
                            make_operand(1'b0, 5'd0, b), 32'd0, 1'b0, 32'd0, rob), '0);
    send_dispatch(make_disp(rs_pkg::OP_SUB, make_operand(1'b0, 5'd0, next_rand()),
                            make_operand(1'b0, 5'd0, next_rand()), 32'd0, 1'b0, 32'd0,
                            next_rob()), '0);
    wait_cdb(lat);
    check_cdb("flush in flight", make_cdb(rob, a + b), alu_cdb_o);
    pulse_flush();
    if (alu_cdb_o.valid) begin
      fail_run("ALU result still valid right after a flush");
    end
    expect_quiet("flushed in flight", 4);
    fill_slots(5'd26, vals, robs);
    check_full("flush before", 1'b1, full_o);
    pulse_flush();
    check_full("flush after", 1'b0, full_o);
    pulse_lsb(5'd26, next_rand());
    expect_quiet("flushed entries", 6);
    run_single("fresh after flush", rs_pkg::OP_SLT, 1'b0, 1'b0);
  endtask

  // watchdog
  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    clk_in       = 1'b0;
    rst_n_i      = 1'b0;
    rdy_i        = 1'b1;
    flush_i      = 1'b0;
    disp_valid_i = 1'b0;
    disp_i       = '0;
    lsb_cdb_i    = '0;
    rng_state    = 32'hd364;
    rob_seq      = '0;
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_n_i = 1'b1;
    check_full("after reset", 1'b0, full_o);
    expect_quiet("after reset", 2);
    independent_ops();
    alu_dependency();
    lsb_wakeup();
    fill_and_order();
    stall_and_flush();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/rs_pkg.sv
rtl/rs_alloc.sv
rtl/rs_entry.sv
rtl/rs_issue_select.sv
rtl/rs_alu.sv
rtl/rs_top.sv
verif/rs_tb.sv
